// File: common/capture_pkg.sv
package capture_pkg;

    // Video and word widths
    localparam int PIXEL_W    = 24;
    localparam int WORD_W     = 32;
    localparam int MEM_ADDR_W = 10;
    localparam int MEM_DEPTH  = 1024;
    localparam int COUNT_W    = 11;

    // Command word fields
    localparam int OP_MSB   = 31;
    localparam int OP_LSB   = 30;
    localparam int LEN_MSB  = 19;
    localparam int LEN_LSB  = 10;
    localparam int ADDR_MSB = 9;
    localparam int ADDR_LSB = 0;

    // Status word flags, count sits in the low COUNT_W bits
    localparam int STATUS_VALID_BIT = 31;
    localparam int STATUS_ARMED_BIT = 30;

    // Command strobe to first reply word
    localparam int RD_LATENCY = 3;

    typedef enum logic [1:0] {
        OP_NOP     = 2'd0,
        OP_CAPTURE = 2'd1,
        OP_READ    = 2'd2,
        OP_STATUS  = 2'd3
    } opcode_e;

    typedef enum logic [1:0] {
        CAP_IDLE       = 2'd0,
        CAP_WAIT_FRAME = 2'd1,
        CAP_ACTIVE     = 2'd2
    } cap_state_e;

    typedef struct packed {
        logic               de;
        logic               hsync;
        logic               vsync;
        logic [PIXEL_W-1:0] rgb;
    } video_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] word;
    } cmd_t;

    typedef struct packed {
        logic                  we;
        logic [MEM_ADDR_W-1:0] addr;
        logic [WORD_W-1:0]     data;
    } mem_wr_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_ADDR_W-1:0] start;
        logic [MEM_ADDR_W-1:0] len;
        logic                  status;
    } read_req_t;

    typedef struct packed {
        logic              valid;
        logic              last;
        logic [WORD_W-1:0] data;
    } resp_t;

endpackage

// File: design/frame_memory.sv
`timescale 1ns/1ps

module frame_memory (
    input  logic                                clk_i,
    input  capture_pkg::mem_wr_t                wr_i,
    input  logic [capture_pkg::MEM_ADDR_W-1:0]  rd_addr_i,
    output logic [capture_pkg::WORD_W-1:0]      rd_data_o
);
    import capture_pkg::*;

    logic [WORD_W-1:0] mem [MEM_DEPTH];

    always_ff @(posedge clk_i) begin
        if (wr_i.we) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// File: frame_capture/frame_capture.sv
`timescale 1ns/1ps

module frame_capture (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             arm_i,
    input  capture_pkg::video_t              video_i,
    output capture_pkg::mem_wr_t             mem_wr_o,
    output logic                             armed_o,
    output logic                             done_o,
    output logic [capture_pkg::COUNT_W-1:0]  count_o
);
    import capture_pkg::*;

    cap_state_e            state_q;
    cap_state_e            state_d;
    logic                  vsync_q;
    logic                  vsync_rise;
    logic                  full;
    logic                  pix_take;
    logic [COUNT_W-1:0]    count_q;
    logic                  we_q;
    logic [MEM_ADDR_W-1:0] wr_addr_q;
    logic [WORD_W-1:0]     wr_data_q;

    assign vsync_rise = video_i.vsync && !vsync_q;
    assign full       = (count_q == COUNT_W'(MEM_DEPTH));

    // Pixels in the closing edge cycle belong to the next frame
    assign pix_take = (state_q == CAP_ACTIVE) && !vsync_rise && video_i.de && !full;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CAP_IDLE:       if (arm_i) state_d = CAP_WAIT_FRAME;
            CAP_WAIT_FRAME: if (vsync_rise) state_d = CAP_ACTIVE;
            CAP_ACTIVE:     if (vsync_rise) state_d = CAP_IDLE;
            default:        state_d = CAP_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= CAP_IDLE;
            vsync_q <= 1'b0;
            count_q <= '0;
            done_o  <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            vsync_q <= video_i.vsync;
            done_o  <= (state_q == CAP_ACTIVE) && vsync_rise;
            we_q    <= pix_take;
            if ((state_q == CAP_WAIT_FRAME) && vsync_rise) begin
                count_q <= '0;
            end else if (pix_take) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // Zero-extended pixel, address follows the running count
    always_ff @(posedge clk_i) begin
        if (pix_take) begin
            wr_addr_q <= count_q[MEM_ADDR_W-1:0];
            wr_data_q <= {{(WORD_W-PIXEL_W){1'b0}}, video_i.rgb};
        end
    end

    assign mem_wr_o = '{we: we_q, addr: wr_addr_q, data: wr_data_q};
    assign armed_o  = (state_q != CAP_IDLE);
    assign count_o  = count_q;

    // Count saturates at the memory depth
    a_no_write_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        count_q <= COUNT_W'(MEM_DEPTH)
    );

endmodule

// File: readback/readback_engine.sv
`timescale 1ns/1ps

module readback_engine (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  capture_pkg::read_req_t               req_i,
    input  logic [capture_pkg::WORD_W-1:0]       status_i,
    input  logic [capture_pkg::WORD_W-1:0]       rd_data_i,
    output logic [capture_pkg::MEM_ADDR_W-1:0]   rd_addr_o,
    output logic                                 busy_o,
    output capture_pkg::resp_t                   resp_o
);
    import capture_pkg::*;

    logic                  issue_q;
    logic                  issue_status_q;
    logic [MEM_ADDR_W-1:0] addr_q;
    logic [MEM_ADDR_W-1:0] remain_q;
    logic                  issue_last;
    logic                  out_valid_q;
    logic                  out_last_q;
    logic                  out_status_q;
    logic [WORD_W-1:0]     status_hold_q;

    assign issue_last = issue_q && (remain_q == '0);

    // Issue stage, one address per cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_q        <= 1'b0;
            issue_status_q <= 1'b0;
            addr_q         <= '0;
            remain_q       <= '0;
        end else if (req_i.valid) begin
            issue_q        <= 1'b1;
            issue_status_q <= req_i.status;
            addr_q         <= req_i.start;
            remain_q       <= req_i.status ? '0 : req_i.len;
        end else if (issue_q) begin
            if (issue_last) begin
                issue_q <= 1'b0;
            end else begin
                // Wraps modulo the memory depth
                addr_q   <= addr_q + 1'b1;
                remain_q <= remain_q - 1'b1;
            end
        end
    end

    // Tracks the word in flight through the memory read
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q  <= 1'b0;
            out_last_q   <= 1'b0;
            out_status_q <= 1'b0;
        end else begin
            out_valid_q  <= issue_q;
            out_last_q   <= issue_last;
            out_status_q <= issue_q && issue_status_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_q && issue_status_q) begin
            status_hold_q <= status_i;
        end
    end

    assign rd_addr_o = addr_q;
    assign busy_o    = req_i.valid || issue_q || out_valid_q;

    always_comb begin
        resp_o.valid = out_valid_q;
        resp_o.last  = out_last_q;
        resp_o.data  = out_status_q ? status_hold_q : rd_data_i;
    end

    // Last word comes with valid and no reply follows straight after it
    a_last_with_valid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        resp_o.last |-> resp_o.valid ##1 !resp_o.valid
    );

    // First reply word lands at the fixed command latency
    a_first_word_latency: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        req_i.valid |-> ##(RD_LATENCY-1) resp_o.valid
    );

endmodule

// File: design/command_regs.sv
`timescale 1ns/1ps

module command_regs (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  capture_pkg::cmd_t                    cmd_i,
    input  logic                                 cap_armed_i,
    input  logic                                 cap_done_i,
    input  logic [capture_pkg::COUNT_W-1:0]      cap_count_i,
    input  logic                                 rd_busy_i,
    output logic                                 arm_o,
    output capture_pkg::read_req_t               read_req_o,
    output logic [capture_pkg::WORD_W-1:0]       status_o
);
    import capture_pkg::*;

    opcode_e               op;
    logic [MEM_ADDR_W-1:0] cmd_addr;
    logic [MEM_ADDR_W-1:0] cmd_len;
    logic                  take_arm;
    logic                  take_read;
    logic                  take_status;

    logic                  req_valid_q;
    logic                  req_status_q;
    logic [MEM_ADDR_W-1:0] req_start_q;
    logic [MEM_ADDR_W-1:0] req_len_q;
    logic                  frame_valid_q;
    logic [COUNT_W-1:0]    count_q;

    assign op       = opcode_e'(cmd_i.word[OP_MSB:OP_LSB]);
    assign cmd_addr = cmd_i.word[ADDR_MSB:ADDR_LSB];
    assign cmd_len  = cmd_i.word[LEN_MSB:LEN_LSB];

    // A pending arm counts as armed until the FSM leaves idle
    always_comb begin
        take_arm    = 1'b0;
        take_read   = 1'b0;
        take_status = 1'b0;
        if (cmd_i.valid) begin
            case (op)
                OP_CAPTURE: take_arm    = !cap_armed_i && !arm_o;
                OP_READ:    take_read   = !rd_busy_i;
                OP_STATUS:  take_status = !rd_busy_i;
                default:    ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            arm_o         <= 1'b0;
            req_valid_q   <= 1'b0;
            frame_valid_q <= 1'b0;
            count_q       <= '0;
        end else begin
            arm_o       <= take_arm;
            req_valid_q <= take_read || take_status;
            if (take_arm) begin
                frame_valid_q <= 1'b0;
            end else if (cap_done_i) begin
                frame_valid_q <= 1'b1;
                count_q       <= cap_count_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_read || take_status) begin
            req_start_q  <= cmd_addr;
            req_len_q    <= take_status ? '0 : cmd_len;
            req_status_q <= take_status;
        end
    end

    assign read_req_o = '{valid:  req_valid_q,
                          start:  req_start_q,
                          len:    req_len_q,
                          status: req_status_q};

    always_comb begin
        status_o                   = '0;
        status_o[COUNT_W-1:0]      = count_q;
        status_o[STATUS_ARMED_BIT] = cap_armed_i;
        status_o[STATUS_VALID_BIT] = frame_valid_q;
    end

    // Engine reports busy from the request cycle on
    a_req_not_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        read_req_o.valid |-> rd_busy_i
    );

endmodule

// File: design/capture_top.sv
`timescale 1ns/1ps

module capture_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  capture_pkg::video_t video_i,
    input  capture_pkg::cmd_t   cmd_i,
    output capture_pkg::resp_t  resp_o,
    output logic                capture_done_o
);
    import capture_pkg::*;

    logic                  arm;
    logic                  cap_armed;
    logic                  cap_done;
    logic [COUNT_W-1:0]    cap_count;
    mem_wr_t               mem_wr;
    read_req_t             rd_req;
    logic [WORD_W-1:0]     status_word;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic [WORD_W-1:0]     rd_data;
    logic                  rd_busy;

    assign capture_done_o = cap_done;

    command_regs u_command_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_i       (cmd_i),
        .cap_armed_i (cap_armed),
        .cap_done_i  (cap_done),
        .cap_count_i (cap_count),
        .rd_busy_i   (rd_busy),
        .arm_o       (arm),
        .read_req_o  (rd_req),
        .status_o    (status_word)
    );

    // Capture path
    frame_capture u_frame_capture (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .arm_i    (arm),
        .video_i  (video_i),
        .mem_wr_o (mem_wr),
        .armed_o  (cap_armed),
        .done_o   (cap_done),
        .count_o  (cap_count)
    );

    frame_memory u_frame_memory (
        .clk_i     (clk_i),
        .wr_i      (mem_wr),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    // Reply path
    readback_engine u_readback_engine (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (rd_req),
        .status_i  (status_word),
        .rd_data_i (rd_data),
        .rd_addr_o (rd_addr),
        .busy_o    (rd_busy),
        .resp_o    (resp_o)
    );

endmodule

// File: test/capture_tb.sv
`timescale 1ns/1ps

module capture_tb;
    import capture_pkg::*;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 16;
    // Up to three cycles per pixel, plus blanking and reply slack
    localparam int T1_CYCLES       = 100;
    localparam int T2_CYCLES       = 10 * 3 + 8 * (16 * 3 + 3) + 200;
    localparam int T3_CYCLES       = 100;
    localparam int T4_CYCLES       = 6 * (12 * 3 + 3) + 300;
    localparam int T5_CYCLES       = 11 * (100 * 3 + 3) + 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                     + T4_CYCLES + T5_CYCLES + 1000;

    logic   clk_i = 1'b0;
    logic   rst_n_i;
    video_t video_i;
    cmd_t   cmd_i;
    resp_t  resp_o;
    logic   capture_done_o;

    int          seed = 32'h4a06_f8d3;
    int          cycle_cnt = 0;
    int          done_cnt = 0;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          model_count = 0;
    logic [31:0] model [MEM_DEPTH];
    logic [31:0] exp_q [$];
    logic [31:0] rx_data [$];
    logic        rx_last [$];
    int          rx_cyc [$];

    always #HALF_PERIOD clk_i = ~clk_i;

    capture_top capture_top_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .video_i        (video_i),
        .cmd_i          (cmd_i),
        .resp_o         (resp_o),
        .capture_done_o (capture_done_o)
    );

    // Reply words tagged with the cycle they were sampled in
    always @(posedge clk_i) begin
        if (resp_o.valid) begin
            rx_data.push_back(resp_o.data);
            rx_last.push_back(resp_o.last);
            rx_cyc.push_back(cycle_cnt);
        end
        if (capture_done_o) begin
            done_cnt <= done_cnt + 1;
        end
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    function automatic logic [31:0] make_status(input logic valid, input logic armed,
                                                input int count);
        logic [31:0] w;
        w = '0;
        w[COUNT_W-1:0]      = count[COUNT_W-1:0];
        w[STATUS_ARMED_BIT] = armed;
        w[STATUS_VALID_BIT] = valid;
        return w;
    endfunction

    task automatic video_cycle(input logic de, input logic hs, input logic vs,
                               input logic [PIXEL_W-1:0] rgb);
        @(posedge clk_i);
        video_i <= '{de: de, hsync: hs, vsync: vs, rgb: rgb};
    endtask

    task automatic vsync_pulse();
        repeat (3) video_cycle(1'b0, 1'b0, 1'b1, '0);
        repeat (2) video_cycle(1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic drive_line(input int pixels, input bit in_frame);
        int          gap;
        logic [31:0] rnd;
        for (int p = 0; p < pixels; p++) begin
            gap = {$random(seed)} % 3;
            repeat (gap) video_cycle(1'b0, 1'b0, 1'b0, '0);
            rnd = $random(seed);
            video_cycle(1'b1, 1'b0, 1'b0, rnd[PIXEL_W-1:0]);
            // Kept only until the memory is full
            if (in_frame && model_count < MEM_DEPTH) begin
                model[model_count] = {8'h00, rnd[PIXEL_W-1:0]};
                model_count++;
            end
        end
        repeat (2) video_cycle(1'b0, 1'b1, 1'b0, '0);
        video_cycle(1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic capture_frame(input int lines, input int pixels);
        model_count = 0;
        vsync_pulse();
        repeat (lines) drive_line(pixels, 1'b1);
        vsync_pulse();
    endtask

    task automatic send_cmd(input opcode_e op, input int start, input int len,
                            output int strobe);
        logic [WORD_W-1:0] w;
        w = '0;
        w[OP_MSB:OP_LSB]     = op;
        w[LEN_MSB:LEN_LSB]   = len[MEM_ADDR_W-1:0];
        w[ADDR_MSB:ADDR_LSB] = start[MEM_ADDR_W-1:0];
        @(posedge clk_i);
        cmd_i  <= '{valid: 1'b1, word: w};
        strobe = cycle_cnt + 1;
        @(posedge clk_i);
        cmd_i <= '0;
    endtask

    task automatic wait_done(input int target);
        int waited;
        waited = 0;
        while (done_cnt < target && waited < 40) begin
            @(negedge clk_i);
            waited++;
        end
        repeat (4) @(negedge clk_i);
        check_value("capture_done_o pulses", done_cnt, target);
    endtask

    task automatic check_reply(input string name, input int strobe);
        int waited;
        int n;
        n = exp_q.size();
        waited = 0;
        while (rx_data.size() < n && waited < n + RD_LATENCY + 10) begin
            @(negedge clk_i);
            waited++;
        end
        if (rx_data.size() < n) begin
            $display("%s: reply words did not arrive in time at %0t", name, $time);
            err_cnt++;
        end
        repeat (RD_LATENCY + 4) @(negedge clk_i);
        check_value({name, " word count"}, rx_data.size(), n);
        for (int k = 0; k < n && k < rx_data.size(); k++) begin
            check_value($sformatf("%s data %0d", name, k), rx_data[k], exp_q[k]);
            check_value($sformatf("%s last %0d", name, k), 32'(rx_last[k]), 32'(k == n - 1));
            check_value($sformatf("%s cycle %0d", name, k), rx_cyc[k], strobe + RD_LATENCY + k);
        end
        exp_q.delete();
        rx_data.delete();
        rx_last.delete();
        rx_cyc.delete();
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s done, %0d errors", name, err_cnt - errs_before);
    endtask

    task automatic test_reset_status();
        int strobe;
        int errs;
        errs = err_cnt;
        repeat (20) @(negedge clk_i);
        check_value("reply words after reset", rx_data.size(), 0);
        check_value("done pulses after reset", done_cnt, 0);
        send_cmd(OP_STATUS, 0, 0, strobe);
        exp_q.push_back(make_status(1'b0, 1'b0, 0));
        check_reply("status after reset", strobe);
        report_test("reset_status", errs);
    endtask

    task automatic test_capture_frame();
        int strobe;
        int errs;
        errs = err_cnt;
        send_cmd(OP_CAPTURE, 0, 0, strobe);
        // Pixels ahead of the opening vsync edge
        drive_line(10, 1'b0);
        capture_frame(8, 16);
        wait_done(1);
        send_cmd(OP_STATUS, 0, 0, strobe);
        exp_q.push_back(make_status(1'b1, 1'b0, 128));
        check_reply("status after frame", strobe);
        send_cmd(OP_READ, 0, 0, strobe);
        exp_q.push_back(model[0]);
        check_reply("first stored word", strobe);
        report_test("capture_frame", errs);
    endtask

    task automatic test_read_range();
        int strobe;
        int errs;
        errs = err_cnt;
        for (int k = 0; k < 20; k++) begin
            exp_q.push_back(model[5 + k]);
        end
        send_cmd(OP_READ, 5, 19, strobe);
        check_reply("read 5 to 24", strobe);
        report_test("read_range", errs);
    endtask

    task automatic test_busy_and_rearm();
        int strobe;
        int other;
        int errs;
        errs = err_cnt;
        for (int k = 0; k < 16; k++) begin
            exp_q.push_back(model[k]);
        end
        send_cmd(OP_READ, 0, 15, strobe);
        send_cmd(OP_READ, 100, 3, other);
        send_cmd(OP_STATUS, 0, 0, other);
        send_cmd(OP_NOP, 0, 0, other);
        check_reply("read with commands while busy", strobe);
        send_cmd(OP_NOP, 0, 0, strobe);
        check_reply("nop", strobe);
        send_cmd(OP_CAPTURE, 0, 0, other);
        model_count = 0;
        vsync_pulse();
        repeat (3) drive_line(12, 1'b1);
        send_cmd(OP_CAPTURE, 0, 0, other);
        repeat (3) drive_line(12, 1'b1);
        vsync_pulse();
        wait_done(2);
        send_cmd(OP_STATUS, 0, 0, strobe);
        exp_q.push_back(make_status(1'b1, 1'b0, 72));
        check_reply("status after rearm attempt", strobe);
        report_test("busy_and_rearm", errs);
    endtask

    task automatic test_saturate();
        int strobe;
        int errs;
        errs = err_cnt;
        send_cmd(OP_CAPTURE, 0, 0, strobe);
        capture_frame(11, 100);
        wait_done(3);
        send_cmd(OP_STATUS, 0, 0, strobe);
        exp_q.push_back(make_status(1'b1, 1'b0, MEM_DEPTH));
        check_reply("status after long frame", strobe);
        // Address wraps from the top word back to zero
        exp_q.push_back(model[MEM_DEPTH - 1]);
        exp_q.push_back(model[0]);
        send_cmd(OP_READ, MEM_DEPTH - 1, 1, strobe);
        check_reply("wrapping read", strobe);
        report_test("saturate", errs);
    endtask

    initial begin
        rst_n_i = 1'b0;
        video_i = '0;
        cmd_i   = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        test_reset_status();
        test_capture_frame();
        test_read_range();
        test_busy_and_rearm();
        test_saturate();
        $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: all.f
common/capture_pkg.sv
design/frame_memory.sv
frame_capture/frame_capture.sv
readback/readback_engine.sv
design/command_regs.sv
design/capture_top.sv
test/capture_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= capture_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
